//--- sources.f
design/riscvPkg.sv
design/aluUnit.sv
design/dataMem.sv
design/instrDecoder.sv
design/pcUnit.sv
design/regFile.sv
design/cpuTop.sv
verif/cpuTb.sv

//--- Makefile
# Verilator build and run of the single-cycle RV32I core testbench

VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/programInput.txt
# name, instruction, expected next iaddr, expected x31 (hex), then the assembly
# step line n sits at address 4 * n, lines skipped by a branch or jump never run
x0Zero    fff00f93 00000004 ffffffff  addi x31,x0,-1
x0Zero    00500013 00000008 ffffffff  addi x0,x0,5
x0Zero    00000fb3 0000000c 00000000  add x31,x0,x0
aluOps    800000b7 00000010 00000000  lui x1,0x80000
aluOps    00700113 00000014 00000000  addi x2,x0,7
aluOps    40110fb3 00000018 80000007  sub x31,x2,x1
aluOps    0020afb3 0000001c 00000001  slt x31,x1,x2
aluOps    0020bfb3 00000020 00000000  sltu x31,x1,x2
aluOps    4040df93 00000024 f8000000  srai x31,x1,4
aluOps    0040df93 00000028 08000000  srli x31,x1,4
aluOps    fff14f93 0000002c fffffff8  xori x31,x2,-1
aluOps    00211fb3 00000030 00000380  sll x31,x2,x2
aluOps    fff13f93 00000034 00000001  sltiu x31,x2,-1
aluOps    0020efb3 00000038 80000007  or x31,x1,x2
aluOps    0fffff93 0000003c 00000007  andi x31,x31,0xff
upperImm  12345fb7 00000040 12345000  lui x31,0x12345
upperImm  00001f97 00000044 00001040  auipc x31,1
loadStore 8badf237 00000048 00001040  lui x4,0x8badf
loadStore 7ed20213 0000004c 00001040  addi x4,x4,0x7ed
loadStore 10402023 00000050 00001040  sw x4,0x100(x0)
loadStore 10100f83 00000054 fffffff7  lb x31,0x101(x0)
loadStore 10304f83 00000058 0000008b  lbu x31,0x103(x0)
loadStore 10201f83 0000005c ffff8bad  lh x31,0x102(x0)
loadStore 10005f83 00000060 0000f7ed  lhu x31,0x100(x0)
loadStore 10200123 00000064 0000f7ed  sb x2,0x102(x0)
loadStore 10101023 00000068 0000f7ed  sh x1,0x100(x0)
loadStore 10002f83 0000006c 8b070000  lw x31,0x100(x0)
branches  00210463 00000074 8b070000  beq x2,x2,+8 taken
branches  fff00f93 00000074 ffffffff  skipped
branches  00211463 00000078 8b070000  bne x2,x2,+8 not taken
branches  0020c463 00000080 8b070000  blt x1,x2,+8 taken
branches  fff00f93 00000080 ffffffff  skipped
branches  0020e463 00000084 8b070000  bltu x1,x2,+8 not taken
branches  00115463 0000008c 8b070000  bge x2,x1,+8 taken
branches  fff00f93 0000008c ffffffff  skipped
branches  00117463 00000090 8b070000  bgeu x2,x1,+8 not taken
branches  00116463 00000098 8b070000  bltu x2,x1,+8 taken
branches  fff00f93 00000098 ffffffff  skipped
branches  0020f463 000000a0 8b070000  bgeu x1,x2,+8 taken
branches  fff00f93 000000a0 ffffffff  skipped
branches  00209463 000000a8 8b070000  bne x1,x2,+8 taken
branches  fff00f93 000000a8 ffffffff  skipped
branches  00208463 000000ac 8b070000  beq x1,x2,+8 not taken
branches  00114463 000000b0 8b070000  blt x2,x1,+8 not taken
branches  0020d463 000000b4 8b070000  bge x1,x2,+8 not taken
jumps     00800fef 000000bc 000000b8  jal x31,+8
jumps     fff00f93 000000bc ffffffff  skipped
jumps     0c900293 000000c0 000000b8  addi x5,x0,0xc9
jumps     00028fe7 000000c8 000000c4  jalr x31,0(x5)
jumps     fff00f93 000000c8 ffffffff  skipped
jumps     001f8f93 000000cc 000000c5  addi x31,x31,1

//--- verif/cpuTb.sv
// testbench for the single-cycle RV32I core
// runs a program from a data file and checks iaddr and x31 after every step
`timescale 1ns/100ps

module cpuTb import riscvPkg::*; ();

	localparam wordT resetAddr   = 32'h0000_0000;
	localparam int   maxSteps    = 256;
	localparam int   resetCycles = 16;
	// ADDI x0, x0, 0
	localparam wordT nopWord     = 32'h0000_0013;

	logic instr = 1'b0;
	logic reset;
	wordT idata;
	wordT iaddr;
	wordT x31;

	// program image and expected results, one entry per step line
	string stepName [0:maxSteps-1];
	wordT  imem     [0:maxSteps-1];
	wordT  expNext  [0:maxSteps-1];
	wordT  expX31   [0:maxSteps-1];
	int    numSteps;
	wordT  finalAddr;

	logic  fetchEn = 1'b0;
	wordT  fetchIdx;
	int    stepIdx = 0;
	int    cycles = 0;
	int    cycleLimit = resetCycles;
	int    testErrors;
	int    passCount;
	int    failCount;
	string curTest;

	cpuTop #(.resetAddr(resetAddr), .dmemWords(256)) dut (
		.instr(instr),
		.reset(reset),
		.idata(idata),
		.iaddr(iaddr),
		.x31  (x31)
	);

	always #50 instr = ~instr;

	// instruction memory, NOP in reset and outside the image
	assign fetchIdx = (iaddr - resetAddr) >> 2;
	always_comb begin
		if (fetchEn && (fetchIdx < wordT'(numSteps)))
			idata = imem[fetchIdx[7:0]];
		else
			idata = nopWord;
	end

	// which line retires on this edge, plus the run limit
	always @(posedge instr) begin
		cycles <= cycles + 1;
		if (fetchEn)
			stepIdx <= int'(fetchIdx);
		if (cycles >= cycleLimit) begin
			$display("TIMEOUT after %0d cycles, program never reached its final address", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic loadProgram();
		int    fd;
		int    n;
		string lineBuf;
		string name;
		wordT  word;
		wordT  nextA;
		wordT  xVal;
		numSteps = 0;
		for (int i = 0; i < maxSteps; i++)
			imem[i[7:0]] = nopWord;
		fd = $fopen("verif/programInput.txt", "r");
		if (fd == 0) begin
			$display("could not open verif/programInput.txt");
			failCount++;
		end else begin
			while ($fgets(lineBuf, fd) != 0) begin
				n = $sscanf(lineBuf, "%s %h %h %h", name, word, nextA, xVal);
				// skip comment and blank lines
				if (lineBuf.getc(0) != "#" && n == 4 && numSteps < maxSteps) begin
					stepName[numSteps[7:0]] = name;
					imem[numSteps[7:0]]     = word;
					expNext[numSteps[7:0]]  = nextA;
					expX31[numSteps[7:0]]   = xVal;
					numSteps++;
				end
			end
			$fclose(fd);
			if (numSteps == 0) begin
				$display("no step lines found in verif/programInput.txt");
				failCount++;
			end
		end
	endtask

	task automatic checkAddr(input string name, input wordT expected, input wordT actual);
		if (actual !== expected) begin
			$display("ERROR %s: iaddr expected %h, actual %h", name, expected, actual);
			testErrors++;
		end
	endtask

	task automatic checkWord(input string name, input wordT expected, input wordT actual);
		if (actual !== expected) begin
			$display("ERROR %s: x31 expected %h, actual %h", name, expected, actual);
			testErrors++;
		end
	endtask

	// one line per finished test
	task automatic finishTest();
		if (curTest != "") begin
			if (testErrors == 0) begin
				$display("test %s passed", curTest);
				passCount++;
			end else begin
				$display("test %s failed with %0d errors", curTest, testErrors);
				failCount++;
			end
		end
		curTest = "";
		testErrors = 0;
	endtask

	// compare the line that just retired
	task automatic checkStep();
		string label;
		if (stepIdx < 0 || stepIdx >= numSteps) begin
			if (curTest == "")
				curTest = "strayFetch";
			$display("instruction fetched outside the program image, iaddr now %h", iaddr);
			testErrors++;
		end else begin
			if (stepName[stepIdx[7:0]] != curTest) begin
				finishTest();
				curTest = stepName[stepIdx[7:0]];
			end
			label = $sformatf("%s at %h", curTest, resetAddr + wordT'(4 * stepIdx));
			checkAddr(label, expNext[stepIdx[7:0]], iaddr);
			checkWord(label, expX31[stepIdx[7:0]], x31);
		end
	endtask

	initial begin
		reset      = 1'b1;
		testErrors = 0;
		passCount  = 0;
		failCount  = 0;
		curTest    = "";
		loadProgram();
		finalAddr  = resetAddr + wordT'(4 * numSteps);
		cycleLimit = resetCycles + 2 * numSteps;

		repeat (resetCycles) @(posedge instr);
		reset   <= 1'b0;
		fetchEn <= 1'b1;

		// state right after reset
		@(negedge instr);
		curTest = "reset";
		checkAddr("reset", resetAddr, iaddr);
		checkWord("reset", 32'd0, x31);
		finishTest();

		while (iaddr != finalAddr) begin
			@(posedge instr);
			@(negedge instr);
			checkStep();
		end
		finishTest();

		$display("tests passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- design/cpuTop.sv
// single-cycle RV32I core
// one instruction retires per rising edge of instr
`timescale 1ns/100ps

module cpuTop import riscvPkg::*; #(
	parameter wordT resetAddr = 32'h0000_0000,
	parameter int   dmemWords = 256
) (
	input  logic instr,
	input  logic reset,
	input  wordT idata,
	output wordT iaddr,
	output wordT x31
);

	// decode outputs
	regIdxT     rs1;
	regIdxT     rs2;
	regIdxT     rd;
	wordT       imm;
	aluOpT      aluOp;
	logic       aluSrcImm;
	logic       aluSrcPc;
	logic       regWrite;
	wbSelT      wbSel;
	logic       memWrite;
	logic [1:0] memSize;
	logic       memUnsigned;
	logic       isBranch;
	logic       isJal;
	logic       isJalr;
	logic [2:0] funct3;

	// datapath
	wordT rv1;
	wordT rv2;
	wordT opA;
	wordT opB;
	wordT aluResult;
	logic branchTaken;
	wordT loadData;
	wordT regData;

	// operand select
	// pc feeds AUIPC, imm feeds I/S/U/JALR
	assign opA = aluSrcPc ? iaddr : rv1;
	assign opB = aluSrcImm ? imm : rv2;

	// write-back mux
	assign regData = (wbSel == WB_LOAD) ? loadData :
	                 (wbSel == WB_PC4)  ? iaddr + 32'd4 :
	                 (wbSel == WB_IMM)  ? imm : aluResult;

	instrDecoder decoder (.*);

	pcUnit #(.resetAddr(resetAddr)) pc (.*);

	regFile regs (.*);

	aluUnit alu (.*);

	dataMem #(.dmemWords(dmemWords)) dmem (
		.instr      (instr),
		.reset      (reset),
		.addr       (aluResult),
		.wdata      (rv2),
		.memWrite   (memWrite),
		.memSize    (memSize),
		.memUnsigned(memUnsigned),
		.loadData   (loadData)
	);

endmodule

//--- design/regFile.sv
// 32-entry register file, x0 reads zero, x31 tapped out
`timescale 1ns/100ps

module regFile import riscvPkg::*; (
	input  logic   instr,
	input  logic   reset,
	input  regIdxT rs1,
	input  regIdxT rs2,
	input  regIdxT rd,
	input  logic   regWrite,
	input  wordT   regData,
	output wordT   rv1,
	output wordT   rv2,
	output wordT   x31
);

	wordT regs [0:31];

	// write port, x0 never written
	always_ff @(posedge instr) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (regWrite && (rd != 5'd0)) begin
			regs[rd] <= regData;
		end
	end

	// two async read ports
	assign rv1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rv2 = (rs2 == 5'd0) ? '0 : regs[rs2];

	// observation tap
	assign x31 = regs[31];

endmodule

//--- design/pcUnit.sv
// program counter with next-address select
`timescale 1ns/100ps

module pcUnit import riscvPkg::*; #(
	parameter wordT resetAddr = 32'h0000_0000
) (
	input  logic instr,
	input  logic reset,
	input  logic isBranch,
	input  logic branchTaken,
	input  logic isJal,
	input  logic isJalr,
	input  wordT imm,
	input  wordT aluResult,
	output wordT iaddr
);

	wordT nextAddr;

	always_comb begin
		if (isJalr)
			// rs1 + imm with bit 0 dropped
			nextAddr = {aluResult[31:1], 1'b0};
		else if (isJal || (isBranch && branchTaken))
			nextAddr = iaddr + imm;
		else
			nextAddr = iaddr + 32'd4;
	end

	// one step per edge
	always_ff @(posedge instr) begin
		if (reset)
			iaddr <= resetAddr;
		else
			iaddr <= nextAddr;
	end

endmodule

//--- design/instrDecoder.sv
// instruction decoder for RV32I
// splits idata into register fields, immediate and control levels
`timescale 1ns/100ps

module instrDecoder import riscvPkg::*; (
	input  wordT       idata,
	output regIdxT     rs1,
	output regIdxT     rs2,
	output regIdxT     rd,
	output wordT       imm,
	output aluOpT      aluOp,
	output logic       aluSrcImm,
	output logic       aluSrcPc,
	output logic       regWrite,
	output wbSelT      wbSel,
	output logic       memWrite,
	output logic [1:0] memSize,
	output logic       memUnsigned,
	output logic       isBranch,
	output logic       isJal,
	output logic       isJalr,
	output logic [2:0] funct3
);

	opcodeT opcode;
	immFmtT immFmt;

	// funct3 plus the funct7[5] bit picks the ALU function
	function automatic aluOpT aluOpFor(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	// fixed field positions
	assign rd     = idata[11:7];
	assign funct3 = idata[14:12];
	assign rs1    = idata[19:15];
	assign rs2    = idata[24:20];
	assign opcode = opcodeT'(idata[6:0]);

	// load and store width straight from funct3
	assign memSize     = funct3[1:0];
	assign memUnsigned = funct3[2];

	// immediate by format, sign bit is always idata[31]
	always_comb begin
		case (immFmt)
			IMM_S:   imm = {{20{idata[31]}}, idata[31:25], idata[11:7]};
			IMM_B:   imm = {{20{idata[31]}}, idata[7], idata[30:25], idata[11:8], 1'b0};
			IMM_U:   imm = {idata[31:12], 12'b0};
			IMM_J:   imm = {{12{idata[31]}}, idata[19:12], idata[20], idata[30:21], 1'b0};
			default: imm = {{20{idata[31]}}, idata[31:20]};
		endcase
	end

	// control levels per opcode
	always_comb begin
		// defaults give no writes and pc + 4
		immFmt    = IMM_I;
		aluOp     = ALU_ADD;
		aluSrcImm = 1'b0;
		aluSrcPc  = 1'b0;
		regWrite  = 1'b0;
		wbSel     = WB_ALU;
		memWrite  = 1'b0;
		isBranch  = 1'b0;
		isJal     = 1'b0;
		isJalr    = 1'b0;
		case (opcode)
			RTYPE: begin
				aluOp    = aluOpFor(funct3, idata[30]);
				regWrite = 1'b1;
			end
			ITYPE: begin
				// bit 30 only selects SRAI, ADDI never subtracts
				aluOp     = aluOpFor(funct3, (funct3 == 3'b101) && idata[30]);
				aluSrcImm = 1'b1;
				regWrite  = 1'b1;
			end
			LTYPE: begin
				// address is rs1 + imm
				aluSrcImm = 1'b1;
				regWrite  = 1'b1;
				wbSel     = WB_LOAD;
			end
			STYPE: begin
				immFmt    = IMM_S;
				aluSrcImm = 1'b1;
				memWrite  = 1'b1;
			end
			BTYPE: begin
				immFmt   = IMM_B;
				isBranch = 1'b1;
			end
			JALR: begin
				// target from ALU, link is pc + 4
				aluSrcImm = 1'b1;
				regWrite  = 1'b1;
				wbSel     = WB_PC4;
				isJalr    = 1'b1;
			end
			JAL: begin
				immFmt   = IMM_J;
				regWrite = 1'b1;
				wbSel    = WB_PC4;
				isJal    = 1'b1;
			end
			AUIPC: begin
				immFmt    = IMM_U;
				aluSrcPc  = 1'b1;
				aluSrcImm = 1'b1;
				regWrite  = 1'b1;
			end
			LUI: begin
				immFmt   = IMM_U;
				regWrite = 1'b1;
				wbSel    = WB_IMM;
			end
			default: ;
		endcase
	end

endmodule

//--- design/dataMem.sv
// byte-addressed data RAM with lane steering on stores
// and sign or zero extension on loads
`timescale 1ns/100ps

module dataMem import riscvPkg::*; #(
	parameter int dmemWords = 256
) (
	input  logic       instr,
	input  logic       reset,
	input  wordT       addr,
	input  wordT       wdata,
	input  logic       memWrite,
	input  logic [1:0] memSize,
	input  logic       memUnsigned,
	output wordT       loadData
);

	localparam int idxBits = $clog2(dmemWords);

	wordT             mem [0:dmemWords-1];
	logic [idxBits-1:0] wordIdx;
	logic [3:0]       byteEn;
	wordT             wdataRep;
	wordT             rdWord;
	logic [7:0]       rdByte;
	logic [15:0]      rdHalf;

	// misaligned accesses fall back to the aligned word
	assign wordIdx = addr[idxBits+1:2];

	// lane enables and replicated store data
	always_comb begin
		case (memSize)
			2'b00: begin
				byteEn   = 4'b0001 << addr[1:0];
				wdataRep = {4{wdata[7:0]}};
			end
			2'b01: begin
				byteEn   = addr[1] ? 4'b1100 : 4'b0011;
				wdataRep = {2{wdata[15:0]}};
			end
			default: begin
				byteEn   = 4'b1111;
				wdataRep = wdata;
			end
		endcase
	end

	// store, no write while in reset
	always_ff @(posedge instr) begin
		if (memWrite && !reset) begin
			for (int i = 0; i < 4; i++)
				if (byteEn[i])
					mem[wordIdx][8*i +: 8] <= wdataRep[8*i +: 8];
		end
	end

	// load lane pick
	assign rdWord = mem[wordIdx];
	assign rdByte = rdWord[{addr[1:0], 3'b000} +: 8];
	assign rdHalf = rdWord[{addr[1], 4'b0000} +: 16];

	// extension by size and funct3[2]
	always_comb begin
		case (memSize)
			2'b00:   loadData = {{24{rdByte[7] & ~memUnsigned}}, rdByte};
			2'b01:   loadData = {{16{rdHalf[15] & ~memUnsigned}}, rdHalf};
			default: loadData = rdWord;
		endcase
	end

endmodule

//--- design/aluUnit.sv
// ALU for RV32I arithmetic, logic and shifts
// also evaluates the branch condition on rs1/rs2
`timescale 1ns/100ps

module aluUnit import riscvPkg::*; (
	input  wordT       opA,
	input  wordT       opB,
	input  aluOpT      aluOp,
	input  wordT       rv1,
	input  wordT       rv2,
	input  logic [2:0] funct3,
	output wordT       aluResult,
	output logic       branchTaken
);

	logic [4:0] shamt;

	// shifts only look at the low five bits
	assign shamt = opB[4:0];

	always_comb begin
		case (aluOp)
			ALU_ADD:  aluResult = opA + opB;
			ALU_SUB:  aluResult = opA - opB;
			ALU_SLL:  aluResult = opA << shamt;
			ALU_SLT:  aluResult = {31'b0, $signed(opA) < $signed(opB)};
			ALU_SLTU: aluResult = {31'b0, opA < opB};
			ALU_XOR:  aluResult = opA ^ opB;
			ALU_SRL:  aluResult = opA >> shamt;
			// arithmetic shift keeps the sign
			ALU_SRA:  aluResult = $signed(opA) >>> shamt;
			ALU_OR:   aluResult = opA | opB;
			ALU_AND:  aluResult = opA & opB;
			default:  aluResult = opA + opB;
		endcase
	end

	// branch compare, only consumed when the decoder flags a branch
	always_comb begin
		case (funct3)
			3'b000:  branchTaken = (rv1 == rv2);
			3'b001:  branchTaken = (rv1 != rv2);
			3'b100:  branchTaken = ($signed(rv1) < $signed(rv2));
			3'b101:  branchTaken = ($signed(rv1) >= $signed(rv2));
			3'b110:  branchTaken = (rv1 < rv2);
			3'b111:  branchTaken = (rv1 >= rv2);
			// 010 and 011 are not branches
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

//--- design/riscvPkg.sv
// shared RV32I types for the single-cycle core
// opcodes, ALU functions, immediate formats and write-back sources
package riscvPkg;

	// plain 32-bit data word
	typedef logic [31:0] wordT;

	// register index, x0 to x31
	typedef logic [4:0] regIdxT;

	// major opcodes from idata[6:0]
	typedef enum logic [6:0] {
		RTYPE = 7'b0110011,
		ITYPE = 7'b0010011,
		LTYPE = 7'b0000011,
		STYPE = 7'b0100011,
		BTYPE = 7'b1100011,
		JALR  = 7'b1100111,
		JAL   = 7'b1101111,
		AUIPC = 7'b0010111,
		LUI   = 7'b0110111
	} opcodeT;

	// ALU functions
	// encoding follows {funct7[5], funct3} where that fits
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SUB  = 4'b1000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_SRA  = 4'b1101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111
	} aluOpT;

	// immediate layouts
	typedef enum logic [2:0] {
		IMM_I,
		IMM_S,
		IMM_B,
		IMM_U,
		IMM_J
	} immFmtT;

	// write-back source for rd
	typedef enum logic [1:0] {
		WB_ALU  = 2'b00,
		WB_LOAD = 2'b01,
		WB_PC4  = 2'b10,
		WB_IMM  = 2'b11
	} wbSelT;

endpackage
